// ==== rv32i_core.f ====
src/rv32i_types_pkg.sv
src/control_unit.sv
src/rv32i_reg_file.sv
src/alu.sv
src/branch_res.sv
src/execute_stage.sv
src/fetch_stage.sv
src/rv32i_core.sv
tests/rv32i_core_tb.sv

// ==== src/alu.sv ====
// RV32I integer ALU
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rv32i_types_pkg::alu_op_t alu_op,
  input  rv32i_types_pkg::word_t   port_a,
  input  rv32i_types_pkg::word_t   port_b,
  output rv32i_types_pkg::word_t   port_out
);

  logic [4:0] shamt;

  // Shifts use only the low five bits
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      rv32i_types_pkg::ALU_ADD:  port_out = port_a + port_b;
      rv32i_types_pkg::ALU_SUB:  port_out = port_a - port_b;
      rv32i_types_pkg::ALU_AND:  port_out = port_a & port_b;
      rv32i_types_pkg::ALU_OR:   port_out = port_a | port_b;
      rv32i_types_pkg::ALU_XOR:  port_out = port_a ^ port_b;
      rv32i_types_pkg::ALU_SLL:  port_out = port_a << shamt;
      rv32i_types_pkg::ALU_SRL:  port_out = port_a >> shamt;
      // Arithmetic shift keeps the sign
      rv32i_types_pkg::ALU_SRA:  port_out = $signed(port_a) >>> shamt;
      rv32i_types_pkg::ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      rv32i_types_pkg::ALU_SLTU: port_out = {31'b0, port_a < port_b};
      default:                   port_out = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/branch_res.sv ====
// Branch condition and target
`timescale 1ns/1ns
`default_nettype none

module branch_res (
  input  rv32i_types_pkg::word_t   rs1_data,
  input  rv32i_types_pkg::word_t   rs2_data,
  input  rv32i_types_pkg::word_t   pc,
  input  rv32i_types_pkg::word_t   imm_sb,
  input  rv32i_types_pkg::branch_t branch_type,
  output logic                     branch_taken,
  output rv32i_types_pkg::word_t   branch_addr
);

  logic eq;
  logic lt_s;
  logic lt_u;

  // Shared comparators
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (branch_type)
      rv32i_types_pkg::BEQ:  branch_taken = eq;
      rv32i_types_pkg::BNE:  branch_taken = !eq;
      rv32i_types_pkg::BLT:  branch_taken = lt_s;
      rv32i_types_pkg::BGE:  branch_taken = !lt_s;
      rv32i_types_pkg::BLTU: branch_taken = lt_u;
      rv32i_types_pkg::BGEU: branch_taken = !lt_u;
      default:               branch_taken = 1'b0;
    endcase
  end

  // PC-relative target
  assign branch_addr = pc + imm_sb;

endmodule

`default_nettype wire

// ==== src/control_unit.sv ====
// Instruction decoder
`timescale 1ns/1ns
`default_nettype none

module control_unit (
  input  rv32i_types_pkg::word_t instr,
  output rv32i_types_pkg::ctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // ALU op from funct3 plus the alternate bit (instr[30])
  function automatic rv32i_types_pkg::alu_op_t decode_alu(input logic [2:0] f3,
                                                          input logic alt);
    rv32i_types_pkg::alu_op_t op;
    case (f3)
      3'b000:  op = alt ? rv32i_types_pkg::ALU_SUB : rv32i_types_pkg::ALU_ADD;
      3'b001:  op = rv32i_types_pkg::ALU_SLL;
      3'b010:  op = rv32i_types_pkg::ALU_SLT;
      3'b011:  op = rv32i_types_pkg::ALU_SLTU;
      3'b100:  op = rv32i_types_pkg::ALU_XOR;
      3'b101:  op = alt ? rv32i_types_pkg::ALU_SRA : rv32i_types_pkg::ALU_SRL;
      3'b110:  op = rv32i_types_pkg::ALU_OR;
      default: op = rv32i_types_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    ctrl = '0;
    // Register fields and raw immediates
    ctrl.rs1    = instr[19:15];
    ctrl.rs2    = instr[24:20];
    ctrl.rd     = instr[11:7];
    ctrl.imm_I  = instr[31:20];
    ctrl.imm_S  = {instr[31:25], instr[11:7]};
    ctrl.imm_SB = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_UJ = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_U  = instr[31:12];
    ctrl.load_type   = rv32i_types_pkg::load_t'(funct3);
    ctrl.branch_type = rv32i_types_pkg::branch_t'(funct3);
    ctrl.halt = (instr == rv32i_types_pkg::HALT_INSTR);

    case (opcode)
      rv32i_types_pkg::OP_REG: begin
        ctrl.alu_op = decode_alu(funct3, funct7[5]);
        ctrl.wen    = 1'b1;
        ctrl.w_sel  = 3'd3;
        // Only add/sub and srl/sra have an alternate form
        ctrl.illegal = (funct7 != 7'b0000000) &&
                       !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv32i_types_pkg::OP_IMM: begin
        ctrl.alu_op    = decode_alu(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl.alu_b_sel = 2'd1;
        ctrl.wen       = 1'b1;
        ctrl.w_sel     = 3'd3;
      end
      rv32i_types_pkg::OP_LOAD: begin
        ctrl.alu_b_sel = 2'd1;
        ctrl.dren      = 1'b1;
        ctrl.wen       = 1'b1;
        ctrl.w_sel     = 3'd0;
        ctrl.illegal   = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv32i_types_pkg::OP_STORE: begin
        ctrl.alu_b_sel = 2'd3;
        ctrl.dwen      = 1'b1;
        ctrl.illegal   = funct3[2] || (funct3 == 3'b011);
      end
      rv32i_types_pkg::OP_BRANCH: begin
        ctrl.branch  = 1'b1;
        ctrl.illegal = (funct3[2:1] == 2'b01);
      end
      rv32i_types_pkg::OP_JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 3'd1;
      end
      rv32i_types_pkg::OP_JALR: begin
        ctrl.jump    = 1'b1;
        ctrl.wen     = 1'b1;
        ctrl.w_sel   = 3'd1;
        ctrl.illegal = (funct3 != 3'b000);
      end
      rv32i_types_pkg::OP_LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 3'd2;
      end
      rv32i_types_pkg::OP_AUIPC: begin
        ctrl.alu_a_sel = 2'd1;
        ctrl.alu_b_sel = 2'd2;
        ctrl.wen       = 1'b1;
        ctrl.w_sel     = 3'd3;
      end
      // Halt word lands here too
      default: ctrl.illegal = 1'b1;
    endcase

    // Illegal words have no side effects
    if (ctrl.illegal) begin
      ctrl.wen    = 1'b0;
      ctrl.dren   = 1'b0;
      ctrl.dwen   = 1'b0;
      ctrl.branch = 1'b0;
      ctrl.jump   = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// Execute stage of the two-stage core
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  rv32i_types_pkg::fetch_ex_reg_t fetch_ex,
  output rv32i_types_pkg::dbus_req_t    dmem_req,
  input  rv32i_types_pkg::word_t        dmem_rdata,
  input  logic                          dmem_busy,
  output logic                          redirect,
  output rv32i_types_pkg::word_t        brj_addr,
  output logic                          stall,
  output logic                          halt_req
);

  rv32i_types_pkg::ctrl_t ctrl;
  rv32i_types_pkg::word_t rs1_data;
  rv32i_types_pkg::word_t rs2_data;
  rv32i_types_pkg::word_t w_data;
  logic                   rf_wen;
  rv32i_types_pkg::word_t port_a;
  rv32i_types_pkg::word_t port_b;
  rv32i_types_pkg::word_t alu_out;
  rv32i_types_pkg::word_t imm_i_ext;
  rv32i_types_pkg::word_t imm_s_ext;
  rv32i_types_pkg::word_t imm_sb_ext;
  rv32i_types_pkg::word_t imm_uj_ext;
  rv32i_types_pkg::word_t imm_u_word;
  rv32i_types_pkg::word_t jump_addr;
  rv32i_types_pkg::word_t branch_addr;
  logic                   branch_taken;
  logic [1:0]             byte_offset;
  logic [3:0]             byte_en;
  logic                   mal_addr;
  rv32i_types_pkg::word_t load_shift;
  rv32i_types_pkg::word_t load_ext;

  control_unit cu (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  rv32i_reg_file rf (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (ctrl.rd),
    .w_data   (w_data),
    .wen      (rf_wen)
  );

  alu alu_i (
    .alu_op   (ctrl.alu_op),
    .port_a   (port_a),
    .port_b   (port_b),
    .port_out (alu_out)
  );

  branch_res br (
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (fetch_ex.pc),
    .imm_sb       (imm_sb_ext),
    .branch_type  (ctrl.branch_type),
    .branch_taken (branch_taken),
    .branch_addr  (branch_addr)
  );

  // Immediate sign extension
  assign imm_i_ext  = {{20{ctrl.imm_I[11]}}, ctrl.imm_I};
  assign imm_s_ext  = {{20{ctrl.imm_S[11]}}, ctrl.imm_S};
  assign imm_sb_ext = {{19{ctrl.imm_SB[12]}}, ctrl.imm_SB};
  assign imm_uj_ext = {{11{ctrl.imm_UJ[20]}}, ctrl.imm_UJ};
  assign imm_u_word = {ctrl.imm_U, 12'b0};

  // Operand A
  always_comb begin
    case (ctrl.alu_a_sel)
      2'd0:    port_a = rs1_data;
      2'd1:    port_a = fetch_ex.pc;
      default: port_a = '0;
    endcase
  end

  // Operand B, store offset on the last leg
  always_comb begin
    case (ctrl.alu_b_sel)
      2'd0:    port_b = rs2_data;
      2'd1:    port_b = imm_i_ext;
      2'd2:    port_b = imm_u_word;
      default: port_b = imm_s_ext;
    endcase
  end

  // JAL is pc relative, JALR clears bit 0
  assign jump_addr = ctrl.j_sel ? (fetch_ex.pc + imm_uj_ext)
                                : ((rs1_data + imm_i_ext) & ~32'd1);

  // Byte lane of the access
  assign byte_offset = alu_out[1:0];

  always_comb begin
    case (ctrl.load_type)
      rv32i_types_pkg::LB,
      rv32i_types_pkg::LBU: byte_en = 4'b0001 << byte_offset;
      rv32i_types_pkg::LH,
      rv32i_types_pkg::LHU: byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
      default:              byte_en = 4'b1111;
    endcase
  end

  // Halfwords need even, words need aligned
  always_comb begin
    case (ctrl.load_type)
      rv32i_types_pkg::LH,
      rv32i_types_pkg::LHU: mal_addr = byte_offset[0];
      rv32i_types_pkg::LW:  mal_addr = |byte_offset;
      default:              mal_addr = 1'b0;
    endcase
  end

  // Bus request, dropped when misaligned or empty
  always_comb begin
    dmem_req.ren     = fetch_ex.valid && ctrl.dren && !mal_addr;
    dmem_req.wen     = fetch_ex.valid && ctrl.dwen && !mal_addr;
    dmem_req.addr    = alu_out;
    dmem_req.byte_en = byte_en;
    // Replicate store data on every lane
    case (ctrl.load_type)
      rv32i_types_pkg::LB: dmem_req.wdata = {4{rs2_data[7:0]}};
      rv32i_types_pkg::LH: dmem_req.wdata = {2{rs2_data[15:0]}};
      default:             dmem_req.wdata = rs2_data;
    endcase
  end

  // Wait on the bus while a request is open
  assign stall = (dmem_req.ren || dmem_req.wen) && dmem_busy;

  // Move the addressed lane down to bit 0
  assign load_shift = dmem_rdata >> {byte_offset, 3'b000};

  always_comb begin
    case (ctrl.load_type)
      rv32i_types_pkg::LB:  load_ext = {{24{load_shift[7]}}, load_shift[7:0]};
      rv32i_types_pkg::LH:  load_ext = {{16{load_shift[15]}}, load_shift[15:0]};
      rv32i_types_pkg::LBU: load_ext = {24'b0, load_shift[7:0]};
      rv32i_types_pkg::LHU: load_ext = {16'b0, load_shift[15:0]};
      default:              load_ext = load_shift;
    endcase
  end

  // Write-back source
  always_comb begin
    case (ctrl.w_sel)
      3'd0:    w_data = load_ext;
      3'd1:    w_data = fetch_ex.pc4;
      3'd2:    w_data = imm_u_word;
      default: w_data = alu_out;
    endcase
  end

  // No write for bubbles, stalls or dropped loads
  assign rf_wen = fetch_ex.valid && ctrl.wen && !stall && !(ctrl.dren && mal_addr);

  // Not-taken is assumed, so redirect on taken branches and all jumps
  assign redirect = fetch_ex.valid && !stall && (ctrl.jump || (ctrl.branch && branch_taken));
  assign brj_addr = ctrl.jump ? jump_addr : branch_addr;

  assign halt_req = fetch_ex.valid && ctrl.halt;

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
// Fetch stage and PC
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  logic                           CLK,
  input  logic                           rst_n,
  output rv32i_types_pkg::word_t         imem_addr,
  input  rv32i_types_pkg::word_t         imem_rdata,
  input  logic                           redirect,
  input  rv32i_types_pkg::word_t         brj_addr,
  input  logic                           stall,
  input  logic                           halt_req,
  output logic                           halt,
  output rv32i_types_pkg::fetch_ex_reg_t fetch_ex
);

  rv32i_types_pkg::word_t pc;
  rv32i_types_pkg::word_t pc4;

  assign pc4       = pc + 32'd4;
  assign imem_addr = pc;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc       <= rv32i_types_pkg::RESET_PC;
      fetch_ex <= '0;
      halt     <= 1'b0;
    end else begin
      // Sticky until reset
      if (halt_req) begin
        halt <= 1'b1;
      end
      if (!stall) begin
        if (halt || halt_req) begin
          // PC frozen, only bubbles from here on
          fetch_ex.valid <= 1'b0;
        end else if (redirect) begin
          pc             <= brj_addr;
          fetch_ex.valid <= 1'b0;
        end else begin
          pc             <= pc4;
          fetch_ex.instr <= imem_rdata;
          fetch_ex.pc    <= pc;
          fetch_ex.pc4   <= pc4;
          fetch_ex.valid <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/rv32i_core.sv ====
// Two-stage RV32I core
`timescale 1ns/1ns
`default_nettype none

module rv32i_core (
  input  logic                       CLK,
  input  logic                       rst_n,
  output rv32i_types_pkg::word_t     imem_addr,
  input  rv32i_types_pkg::word_t     imem_rdata,
  output rv32i_types_pkg::dbus_req_t dmem_req,
  input  rv32i_types_pkg::word_t     dmem_rdata,
  input  logic                       dmem_busy,
  output logic                       halt
);

  rv32i_types_pkg::fetch_ex_reg_t fetch_ex;
  rv32i_types_pkg::word_t         brj_addr;
  logic                           redirect;
  logic                           stall;
  logic                           halt_req;

  fetch_stage fetch (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .redirect   (redirect),
    .brj_addr   (brj_addr),
    .stall      (stall),
    .halt_req   (halt_req),
    .halt       (halt),
    .fetch_ex   (fetch_ex)
  );

  execute_stage execute (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .fetch_ex   (fetch_ex),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .dmem_busy  (dmem_busy),
    .redirect   (redirect),
    .brj_addr   (brj_addr),
    .stall      (stall),
    .halt_req   (halt_req)
  );

endmodule

`default_nettype wire

// ==== src/rv32i_reg_file.sv ====
// Integer register file
`timescale 1ns/1ns
`default_nettype none

module rv32i_reg_file (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic [4:0]             rs1,
  input  logic [4:0]             rs2,
  output rv32i_types_pkg::word_t rs1_data,
  output rv32i_types_pkg::word_t rs2_data,
  input  logic [4:0]             rd,
  input  rv32i_types_pkg::word_t w_data,
  input  logic                   wen
);

  // x0 has no storage
  rv32i_types_pkg::word_t regs [1:31];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= w_data;
    end
  end

  // Combinational reads, x0 forced to zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== src/rv32i_types_pkg.sv ====
// RV32I shared types
`default_nettype none

package rv32i_types_pkg;

  // Basic data word
  typedef logic [31:0] word_t;

  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // Reserved halt word and start address
  localparam word_t HALT_INSTR = 32'hffff_ffff;
  localparam word_t RESET_PC   = 32'h0000_0000;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Encodings follow funct3 of the branch group
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Load funct3, reused as store width
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  // Decoded control word
  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    alu_op_t     alu_op;
    logic [1:0]  alu_a_sel;    // 0 rs1, 1 pc, 2 zero
    logic [1:0]  alu_b_sel;    // 0 rs2, 1 imm_I, 2 imm_U, 3 imm_S
    logic [2:0]  w_sel;        // 0 load, 1 pc4, 2 imm_U, 3 alu
    logic        wen;
    logic        dren;
    logic        dwen;
    load_t       load_type;
    logic        branch;
    branch_t     branch_type;
    logic        jump;
    logic        j_sel;        // 1 for JAL, 0 for JALR
    logic [11:0] imm_I;
    logic [11:0] imm_S;
    logic [12:0] imm_SB;       // Low zero bit included
    logic [20:0] imm_UJ;       // Low zero bit included
    logic [19:0] imm_U;        // Upper 20 bits only
    logic        halt;
    logic        illegal;
  } ctrl_t;

  // Fetch to execute pipeline register
  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pc4;
    logic  valid;
  } fetch_ex_reg_t;

  // Data bus request
  typedef struct packed {
    logic       ren;
    logic       wen;
    word_t      addr;
    logic [3:0] byte_en;
    word_t      wdata;
  } dbus_req_t;

endpackage

`default_nettype wire

// ==== tests/rv32i_core_tb.sv ====
// Testbench for the two-stage RV32I core
`timescale 1ns/1ns
`default_nettype none

module rv32i_core_tb;

  localparam int HALT_LIMIT  = 5000;
  localparam int MODEL_LIMIT = 10000;
  localparam int MEM_BYTES   = 1024;

  logic                       CLK;
  logic                       rst_n;
  rv32i_types_pkg::word_t     imem_addr;
  rv32i_types_pkg::word_t     imem_rdata;
  rv32i_types_pkg::dbus_req_t dmem_req;
  rv32i_types_pkg::word_t     dmem_rdata;
  logic                       dmem_busy;
  logic                       halt;

  // Program image and model state
  rv32i_types_pkg::word_t     prog [256];
  int                         prog_len;
  rv32i_types_pkg::word_t     mreg [32];
  logic [7:0]                 model_mem [MEM_BYTES];
  logic [7:0]                 bus_mem [MEM_BYTES];
  rv32i_types_pkg::dbus_req_t exp_q [$];

  // Bus model state
  int                         served;
  logic                       active;
  int                         busy_left;
  rv32i_types_pkg::dbus_req_t held;
  int                         cyc;

  rv32i_core UUT (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .dmem_busy  (dmem_busy),
    .halt       (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input rv32i_types_pkg::word_t exp,
                             input rv32i_types_pkg::word_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Instruction encoders
  function automatic rv32i_types_pkg::word_t enc_s(input logic [11:0] imm,
                                                   input logic [4:0] rs2,
                                                   input logic [4:0] rs1,
                                                   input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32i_types_pkg::OP_STORE};
  endfunction

  function automatic rv32i_types_pkg::word_t enc_b(input logic [12:0] imm,
                                                   input logic [4:0] rs2,
                                                   input logic [4:0] rs1,
                                                   input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
            rv32i_types_pkg::OP_BRANCH};
  endfunction

  function automatic rv32i_types_pkg::word_t enc_j(input logic [20:0] imm,
                                                   input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32i_types_pkg::OP_JAL};
  endfunction

  // Reference semantics from the ISA rules
  function automatic rv32i_types_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                     input rv32i_types_pkg::word_t a,
                                                     input rv32i_types_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rv32i_types_pkg::word_t a,
                                      input rv32i_types_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Width code is 0 for byte, 1 for half and 2 for word
  function automatic logic misaligned(input logic [1:0] w, input logic [1:0] off);
    return (w == 2'd1 && off[0]) || (w == 2'd2 && off != 2'd0);
  endfunction

  function automatic logic [3:0] lanes(input logic [1:0] w, input logic [1:0] off);
    case (w)
      2'd0: return 4'b0001 << off;
      2'd1: return 4'b0011 << off;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic rv32i_types_pkg::word_t replicate(input logic [1:0] w,
                                                       input rv32i_types_pkg::word_t v);
    case (w)
      2'd0: return {4{v[7:0]}};
      2'd1: return {2{v[15:0]}};
      default: return v;
    endcase
  endfunction

  task automatic emit(input rv32i_types_pkg::word_t ins);
    prog[prog_len] = ins;
    prog_len++;
  endtask

  // Random program with forward control flow only
  task automatic generate_program();
    logic [2:0]  br_f3 [6];
    logic [2:0]  ld_f3 [5];
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    int          k;
    int          sel;
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    for (int i = 0; i < 256; i++) begin
      prog[i] = rv32i_types_pkg::HALT_INSTR;
    end
    prog_len = 0;
    while (prog_len < 200) begin
      sel = $urandom % 16;
      rd  = 5'(1 + $urandom % 31);
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      f3  = 3'($urandom);
      k   = 1 + $urandom % 4;
      if (sel < 6) begin
        // Shift immediates need a legal funct7
        imm = 12'($urandom);
        if (f3 == 3'd1) begin
          imm[11:5] = 7'b0;
        end
        if (f3 == 3'd5) begin
          imm[11:5] = {1'b0, imm[10], 5'b0};
        end
        emit({imm, rs1, f3, rd, rv32i_types_pkg::OP_IMM});
      end else if (sel < 9) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'b0100000 : 7'b0;
        emit({f7, rs2, rs1, f3, rd, rv32i_types_pkg::OP_REG});
      end else if (sel == 9) begin
        emit({20'($urandom), rd,
              ($urandom % 2) ? rv32i_types_pkg::OP_LUI : rv32i_types_pkg::OP_AUIPC});
      end else if (sel < 12) begin
        // Load from x0 base then store the result aligned
        f3 = ld_f3[$urandom % 5];
        emit({12'($urandom % 768), 5'd0, f3, rd, rv32i_types_pkg::OP_LOAD});
        emit(enc_s(12'(4 * ($urandom % 192)), rd, 5'd0, 3'd2));
      end else if (sel == 12) begin
        emit(enc_s(12'($urandom % 768), rs2, 5'd0, 3'($urandom % 3)));
      end else if (sel == 13) begin
        emit(enc_b(13'(4 * k), rs2, rs1, br_f3[$urandom % 6]));
      end else if (sel == 14) begin
        emit(enc_j(21'(4 * k), rd));
      end else begin
        // Absolute forward target with bit 0 sometimes set
        emit({12'(4 * (prog_len + k) + $urandom % 2), 5'd0, 3'd0, rd,
              rv32i_types_pkg::OP_JALR});
      end
    end
    // Register dump at 0x300
    for (int r = 1; r < 32; r++) begin
      emit(enc_s(12'(12'h300 + 4 * (r - 1)), 5'(r), 5'd0, 3'd2));
    end
    emit(rv32i_types_pkg::HALT_INSTR);
  endtask

  // Sequential ISA model that collects the expected bus requests
  task automatic model_run();
    rv32i_types_pkg::word_t     ins;
    rv32i_types_pkg::word_t     pc;
    rv32i_types_pkg::word_t     next_pc;
    rv32i_types_pkg::word_t     a;
    rv32i_types_pkg::word_t     b;
    rv32i_types_pkg::word_t     res;
    rv32i_types_pkg::word_t     addr;
    rv32i_types_pkg::word_t     imm_i;
    rv32i_types_pkg::word_t     imm_s;
    rv32i_types_pkg::word_t     imm_b;
    rv32i_types_pkg::word_t     imm_j;
    rv32i_types_pkg::dbus_req_t req;
    logic [2:0]                 f3;
    logic [7:0]                 bt;
    logic [15:0]                hw;
    logic                       wr;
    int                         steps;
    pc    = rv32i_types_pkg::RESET_PC;
    steps = 0;
    for (int r = 0; r < 32; r++) begin
      mreg[r] = '0;
    end
    while (prog[pc[9:2]] != rv32i_types_pkg::HALT_INSTR) begin
      if (steps >= MODEL_LIMIT) begin
        fail_run("model did not reach the halt word");
      end
      ins     = prog[pc[9:2]];
      f3      = ins[14:12];
      a       = mreg[ins[19:15]];
      b       = mreg[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      res     = '0;
      wr      = 1'b1;
      next_pc = pc + 32'd4;
      req     = '0;
      case (ins[6:0])
        rv32i_types_pkg::OP_LUI:   res = {ins[31:12], 12'b0};
        rv32i_types_pkg::OP_AUIPC: res = pc + {ins[31:12], 12'b0};
        rv32i_types_pkg::OP_IMM:   res = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
        rv32i_types_pkg::OP_REG:   res = alu_ref(f3, ins[30], a, b);
        rv32i_types_pkg::OP_JAL: begin
          res     = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        rv32i_types_pkg::OP_JALR: begin
          res     = pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
        rv32i_types_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if (branch_ref(f3, a, b)) begin
            next_pc = pc + imm_b;
          end
        end
        rv32i_types_pkg::OP_LOAD: begin
          addr = a + imm_i;
          // Misaligned loads vanish without a write
          wr = !misaligned(f3[1:0], addr[1:0]);
          if (wr) begin
            req.ren     = 1'b1;
            req.addr    = addr;
            req.byte_en = lanes(f3[1:0], addr[1:0]);
            exp_q.push_back(req);
            bt = model_mem[addr[9:0]];
            hw = {model_mem[addr[9:0] + 10'd1], bt};
            case (f3)
              3'd0: res = {{24{bt[7]}}, bt};
              3'd1: res = {{16{hw[15]}}, hw};
              3'd4: res = {24'b0, bt};
              3'd5: res = {16'b0, hw};
              default: res = {model_mem[addr[9:0] + 10'd3], model_mem[addr[9:0] + 10'd2], hw};
            endcase
          end
        end
        rv32i_types_pkg::OP_STORE: begin
          wr   = 1'b0;
          addr = a + imm_s;
          if (!misaligned(f3[1:0], addr[1:0])) begin
            req.wen     = 1'b1;
            req.addr    = addr;
            req.byte_en = lanes(f3[1:0], addr[1:0]);
            req.wdata   = replicate(f3[1:0], b);
            exp_q.push_back(req);
            for (int i = 0; i < (1 << f3[1:0]); i++) begin
              model_mem[addr[9:0] + 10'(i)] = b[8 * i +: 8];
            end
          end
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        mreg[ins[11:7]] = res;
      end
      pc = next_pc;
      steps++;
    end
  endtask

  // Completes one bus request against the expected list
  task automatic serve_request();
    rv32i_types_pkg::dbus_req_t exp;
    logic [9:0]                 base;
    string                      tag;
    if (dmem_req.addr >= MEM_BYTES) begin
      fail_run("data address outside the 1 KiB memory");
    end else if (served >= exp_q.size()) begin
      fail_run("bus request beyond the expected sequence");
    end else begin
      exp = exp_q[served];
      tag = $sformatf("bus_req%0d", served);
      check_value({tag, "_ren"}, exp.ren, dmem_req.ren);
      check_value({tag, "_wen"}, exp.wen, dmem_req.wen);
      check_value({tag, "_addr"}, exp.addr, dmem_req.addr);
      check_value({tag, "_byte_en"}, exp.byte_en, dmem_req.byte_en);
      if (exp.wen) begin
        check_value({tag, "_wdata"}, exp.wdata, dmem_req.wdata);
      end
      base = {dmem_req.addr[9:2], 2'b00};
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.wen && dmem_req.byte_en[i]) begin
          bus_mem[base + 10'(i)] = dmem_req.wdata[8 * i +: 8];
        end
      end
      dmem_rdata = {bus_mem[base + 10'd3], bus_mem[base + 10'd2],
                    bus_mem[base + 10'd1], bus_mem[base]};
      served++;
    end
  endtask

  // Instruction port and data memory driven on the falling edge
  always @(negedge CLK) begin
    imem_rdata = (imem_addr < 32'd1024) ? prog[imem_addr[9:2]]
                                        : rv32i_types_pkg::HALT_INSTR;
    if (dmem_req.ren === 1'b1 || dmem_req.wen === 1'b1) begin
      if (!active) begin
        active    = 1'b1;
        busy_left = $urandom % 4;
        held      = dmem_req;
      end else if (dmem_req !== held) begin
        fail_run("data request changed while the bus was busy");
      end
      if (busy_left > 0) begin
        dmem_busy  = 1'b1;
        dmem_rdata = $urandom;
        busy_left--;
      end else begin
        dmem_busy = 1'b0;
        serve_request();
        active = 1'b0;
      end
    end else begin
      dmem_busy = 1'b0;
      if (active) begin
        fail_run("data request withdrawn before the bus finished it");
      end
    end
  end

  initial begin
    void'($urandom(49568));
    rst_n      = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    dmem_busy  = 1'b0;
    active     = 1'b0;
    busy_left  = 0;
    served     = 0;
    held       = '0;
    // Fill byte depends on all ten address bits
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'(i ^ (i >> 3));
      bus_mem[i]   = model_mem[i];
    end
    generate_program();
    model_run();

    // First edge clears the registers
    @(posedge CLK);
    repeat (8) begin
      @(negedge CLK);
      check_value("reset_halt", 32'd0, halt);
      check_value("reset_ren", 32'd0, dmem_req.ren);
      check_value("reset_wen", 32'd0, dmem_req.wen);
      check_value("reset_imem_addr", rv32i_types_pkg::RESET_PC, imem_addr);
    end
    rst_n = 1'b1;

    // Run until halt within a cycle limit
    cyc = 0;
    while (halt !== 1'b1 && cyc < HALT_LIMIT) begin
      @(negedge CLK);
      cyc++;
    end
    if (halt !== 1'b1) begin
      fail_run("halt never rose within the cycle limit");
    end
    check_value("requests_at_halt", exp_q.size(), served);

    // Halt is sticky and the bus stays quiet
    repeat (20) begin
      @(negedge CLK);
      check_value("halt_sticky", 32'd1, halt);
      check_value("ren_after_halt", 32'd0, dmem_req.ren);
      check_value("wen_after_halt", 32'd0, dmem_req.wen);
    end

    for (int i = 0; i < MEM_BYTES; i++) begin
      check_value($sformatf("final_mem_%0h", i), model_mem[i], bus_mem[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
